// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mmu
RTL_TOP   ?= mmu_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wall -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
mmu_pkg.sv
walk_if.sv
tlb.sv
page_walker.sv
translate_ctrl.sv
mmu_top.sv
tb_clock_gen.sv
tb_mmu_asserts.sv
tb_mmu.sv

// ==== mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    localparam int VA_W          = 48;
    localparam int PA_W          = 56;
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = VA_W - PAGE_OFFSET_W;  // 36 bits.
    localparam int PPN_W         = PA_W - PAGE_OFFSET_W;  // 44 bits.
    localparam int VPN_INDEX_W   = 9;
    localparam int PT_LEVELS     = 4;

    localparam int PTE_W         = 64;
    localparam int BUS_DATA_W    = 64;
    localparam int LINE_BEATS    = 8;
    localparam int TLB_ENTRIES   = 8;

    // pte layout, sv48 style without permission bits
    localparam int PTE_VALID_BIT = 0;
    localparam int PTE_LEAF_BIT  = 1;
    localparam int PTE_PPN_LSB   = 10;  // ppn occupies 53..10.

    typedef logic [VA_W-1:0]                vaddr_t;
    typedef logic [PA_W-1:0]                paddr_t;
    typedef logic [VPN_W-1:0]               vpn_t;
    typedef logic [PPN_W-1:0]               ppn_t;
    typedef logic [PTE_W-1:0]               pte_t;
    typedef logic [BUS_DATA_W-1:0]          bus_data_t;
    typedef logic [$clog2(PT_LEVELS)-1:0]   level_t;
    typedef logic [$clog2(LINE_BEATS)-1:0]  beat_t;

endpackage

`default_nettype wire

// ==== mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  mmu_pkg::vaddr_t    va,
    input  mmu_pkg::ppn_t      satp_ppn,
    input  logic               flush,
    output logic               ready,
    output logic               resp_valid,
    output mmu_pkg::paddr_t    pa,
    output logic               fault,
    output logic               bus_req,
    input  logic               bus_grant,
    output logic               bus_busy,
    output logic               bus_req_cyc,
    output mmu_pkg::paddr_t    bus_addr,
    input  logic               bus_resp_cyc,
    input  mmu_pkg::bus_data_t bus_resp,
    output logic               bus_resp_ack
);

    mmu_pkg::vpn_t lookup_vpn;
    logic          hit;
    mmu_pkg::ppn_t hit_ppn;
    logic          refill;
    mmu_pkg::vpn_t refill_vpn;
    mmu_pkg::ppn_t refill_ppn;

    walk_if walk_link ();

    tlb u_tlb (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .lookup_vpn (lookup_vpn),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .refill     (refill),
        .refill_vpn (refill_vpn),
        .refill_ppn (refill_ppn)
    );

    translate_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .va         (va),
        .ready      (ready),
        .resp_valid (resp_valid),
        .pa         (pa),
        .fault      (fault),
        .lookup_vpn (lookup_vpn),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .refill     (refill),
        .refill_vpn (refill_vpn),
        .refill_ppn (refill_ppn),
        .walk       (walk_link.ctrl)
    );

    page_walker u_walker (
        .clk          (clk),
        .reset        (reset),
        .walk         (walk_link.walker),
        .satp_ppn     (satp_ppn),
        .bus_req      (bus_req),
        .bus_grant    (bus_grant),
        .bus_busy     (bus_busy),
        .bus_req_cyc  (bus_req_cyc),
        .bus_addr     (bus_addr),
        .bus_resp_cyc (bus_resp_cyc),
        .bus_resp     (bus_resp),
        .bus_resp_ack (bus_resp_ack)
    );

endmodule

`default_nettype wire

// ==== page_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_walker (
    input  logic               clk,
    input  logic               reset,
    walk_if.walker             walk,
    input  mmu_pkg::ppn_t      satp_ppn,
    output logic               bus_req,
    input  logic               bus_grant,
    output logic               bus_busy,
    output logic               bus_req_cyc,
    output mmu_pkg::paddr_t    bus_addr,
    input  logic               bus_resp_cyc,
    input  mmu_pkg::bus_data_t bus_resp,
    output logic               bus_resp_ack
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_RESP,
        S_DONE
    } state_t;

    localparam mmu_pkg::level_t LAST_LEVEL = mmu_pkg::level_t'(mmu_pkg::PT_LEVELS - 1);
    localparam mmu_pkg::beat_t  LAST_BEAT  = mmu_pkg::beat_t'(mmu_pkg::LINE_BEATS - 1);
    localparam int              BEAT_W     = $bits(mmu_pkg::beat_t);

    state_t state;
    state_t next_state;

    mmu_pkg::level_t level;
    mmu_pkg::beat_t  beat;
    mmu_pkg::vpn_t   vpn_q;
    mmu_pkg::ppn_t   base_ppn;
    mmu_pkg::pte_t   pte_q;
    mmu_pkg::ppn_t   result_ppn;
    logic            result_fault;

    logic [mmu_pkg::VPN_INDEX_W-1:0] vpn_index;
    mmu_pkg::beat_t                  sel_beat;
    logic                            beat_in;
    logic                            last_beat;
    mmu_pkg::pte_t                   pte_now;
    mmu_pkg::ppn_t                   pte_ppn;
    logic                            pte_valid;
    logic                            pte_leaf;
    logic                            pte_fault;
    logic                            pte_final;

    // level 0 takes the top nine vpn bits
    assign vpn_index = vpn_q[(LAST_LEVEL - level) * mmu_pkg::VPN_INDEX_W +: mmu_pkg::VPN_INDEX_W];
    assign sel_beat  = vpn_index[BEAT_W-1:0];

    assign beat_in   = bus_resp_cyc && ((state == S_WAIT) || (state == S_RESP));
    assign last_beat = beat_in && (beat == LAST_BEAT);

    // the indexed beat may be the one arriving now
    assign pte_now   = (beat == sel_beat) ? bus_resp : pte_q;
    assign pte_valid = pte_now[mmu_pkg::PTE_VALID_BIT];
    assign pte_leaf  = pte_now[mmu_pkg::PTE_LEAF_BIT];
    assign pte_ppn   = pte_now[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPN_W];

    // a leaf is legal only at the last level.
    assign pte_fault = !pte_valid || (pte_leaf != (level == LAST_LEVEL));
    assign pte_final = pte_fault || pte_leaf;

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (walk.start) begin
                    next_state = S_REQ;
                end
            end
            S_REQ: begin
                if (bus_grant) begin
                    next_state = S_WAIT;
                end
            end
            S_WAIT: begin
                if (beat_in) begin
                    next_state = S_RESP;
                end
            end
            S_RESP: begin
                if (last_beat) begin
                    next_state = pte_final ? S_DONE : S_REQ;
                end
            end
            S_DONE: next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    assign bus_req      = (state == S_REQ) || (state == S_WAIT) || (state == S_RESP);
    assign bus_busy     = ((state == S_REQ) && bus_grant) || (state == S_WAIT) ||
                          (state == S_RESP);
    assign bus_req_cyc  = (state == S_REQ) && bus_grant;
    assign bus_addr     = {base_ppn, vpn_index[mmu_pkg::VPN_INDEX_W-1:BEAT_W],
                           6'd0};  // 64 byte line.
    assign bus_resp_ack = beat_in;

    assign walk.done  = (state == S_DONE);
    assign walk.ppn   = result_ppn;
    assign walk.fault = result_fault;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            level <= '0;
            beat  <= '0;
        end else begin
            state <= next_state;
            if ((state == S_IDLE) && walk.start) begin
                level <= '0;
            end else if (last_beat && !pte_final) begin
                level <= level + 1'b1;  // descend.
            end
            if (state == S_REQ) begin
                beat <= '0;
            end else if (beat_in) begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && walk.start) begin
            vpn_q    <= walk.vpn;
            base_ppn <= satp_ppn;  // root table.
        end else if (last_beat && !pte_final) begin
            base_ppn <= pte_ppn;
        end
        if (beat_in && (beat == sel_beat)) begin
            pte_q <= bus_resp;
        end
        if (last_beat && pte_final) begin
            result_ppn   <= pte_ppn;
            result_fault <= pte_fault;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 10;  // 20 ns clock.
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mmu;

    localparam int GRANT_DELAY = 2;
    localparam int MEM_DELAY = 3;
    localparam int MAX_LAT = 400;
    localparam int N_TRANSLATIONS = 24;
    localparam int WALK_CYCLES = 120;  // worst case per translation.
    localparam longint WATCHDOG_NS = longint'(N_TRANSLATIONS) * WALK_CYCLES * 20 + 2000;

    logic clk, reset, req_valid, flush, ready, resp_valid, fault;
    logic bus_req, bus_grant, bus_busy, bus_req_cyc, bus_resp_cyc, bus_resp_ack;
    mmu_pkg::vaddr_t va;
    mmu_pkg::ppn_t satp_ppn;
    mmu_pkg::paddr_t pa, bus_addr;
    mmu_pkg::bus_data_t bus_resp;

    logic [63:0] mem [logic [63:0]];  // keyed by word address.
    mmu_pkg::paddr_t seen_addrs[$];
    mmu_pkg::paddr_t exp_addrs[$];
    logic bus_req_seen;
    int acked_beats;
    int bstate, cnt, beat;
    logic [63:0] line_key;
    integer seed = 3518;
    int errors = 0;
    int tests = 0;

    tb_clock_gen u_clk (.clk(clk), .reset(reset));

    mmu_top dut (
        .clk(clk), .reset(reset), .req_valid(req_valid), .va(va), .satp_ppn(satp_ppn),
        .flush(flush), .ready(ready), .resp_valid(resp_valid), .pa(pa), .fault(fault),
        .bus_req(bus_req), .bus_grant(bus_grant), .bus_busy(bus_busy),
        .bus_req_cyc(bus_req_cyc), .bus_addr(bus_addr), .bus_resp_cyc(bus_resp_cyc),
        .bus_resp(bus_resp), .bus_resp_ack(bus_resp_ack)
    );

    function automatic logic [63:0] read_word(input logic [63:0] key);
        return mem.exists(key) ? mem[key] : 64'd0;  // unwritten words read as zero.
    endfunction

    // grant, then one address phase, then eight beats after a fixed delay
    always @(negedge clk) begin
        if (reset) begin
            bstate = 0;
            cnt = 0;
            bus_grant = 1'b0;
            bus_resp_cyc = 1'b0;
        end else begin
            if (bus_req) bus_req_seen = 1'b1;
            case (bstate)
                0: begin
                    if (bus_req) begin
                        if (cnt == GRANT_DELAY) begin
                            bus_grant = 1'b1;
                            cnt = 0;
                            bstate = 1;
                        end else cnt++;
                    end
                end
                1: begin
                    line_key = 64'(bus_addr) >> 3;
                    bus_grant = 1'b0;
                    bstate = 2;
                end
                2: begin
                    if (cnt == MEM_DELAY) begin
                        cnt = 0;
                        beat = 0;
                        bstate = 3;
                    end else cnt++;
                end
                default: begin
                    if (beat < mmu_pkg::LINE_BEATS) begin
                        bus_resp_cyc = 1'b1;
                        bus_resp = read_word(line_key + 64'(beat));
                        beat++;
                    end else begin
                        bus_resp_cyc = 1'b0;
                        bus_resp = '0;
                        bstate = 0;
                    end
                end
            endcase
        end
    end

    // address phases and acknowledged beats.
    always @(posedge clk) begin
        if (!reset) begin
            if (bus_req_cyc) begin
                seen_addrs.push_back(bus_addr);
            end
            if (bus_resp_cyc && bus_resp_ack) begin
                acked_beats++;
            end
        end
    end

    function automatic mmu_pkg::ppn_t rand_ppn();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[43:0];
    endfunction

    function automatic logic [63:0] make_pte(input mmu_pkg::ppn_t p, input logic leaf,
                                             input logic valid);
        return (64'(p) << 10) | (64'(leaf) << 1) | 64'(valid);
    endfunction

    // kind 0 good, 1 invalid at flevel, 2 leaf at flevel, 3 non-leaf at level 3
    task automatic build_tables(input mmu_pkg::vaddr_t v, input int kind, input int flevel,
                                output mmu_pkg::ppn_t root, output mmu_pkg::ppn_t leaf);
        mmu_pkg::ppn_t base, next;
        logic [8:0] idx;
        logic [55:0] addr;
        logic stop;
        root = rand_ppn();
        leaf = rand_ppn();
        base = root;
        stop = 1'b0;
        exp_addrs.delete();
        for (int l = 0; l < 4; l++) begin
            if (!stop) begin
                idx = v[12 + 9 * (3 - l) +: 9];
                addr = {base, 12'd0} + 56'(idx) * 8;
                exp_addrs.push_back(addr & ~56'd63);
                next = rand_ppn();
                if (kind == 1 && l == flevel) begin
                    mem[64'(addr) >> 3] = 64'd0;
                    stop = 1'b1;
                end else if (kind == 2 && l == flevel) begin
                    mem[64'(addr) >> 3] = make_pte(next, 1'b1, 1'b1);
                    stop = 1'b1;
                end else if (l == 3) begin
                    mem[64'(addr) >> 3] = make_pte(leaf, kind != 3, 1'b1);
                end else begin
                    mem[64'(addr) >> 3] = make_pte(next, 1'b0, 1'b1);
                    base = next;
                end
            end
        end
    endtask

    task automatic translate(input mmu_pkg::vaddr_t v, input mmu_pkg::ppn_t root,
                             output mmu_pkg::paddr_t p, output logic f, output int lat,
                             output logic walked);
        int guard;
        guard = 0;
        while (!ready && guard < MAX_LAT) begin
            @(negedge clk);
            guard++;
        end
        seen_addrs.delete();
        acked_beats = 0;
        bus_req_seen = 1'b0;
        va = v;
        satp_ppn = root;
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!resp_valid && lat < MAX_LAT) begin
            @(negedge clk);
            lat++;
        end
        if (!resp_valid) begin
            $display("Error: no response for va %h", v);
            errors++;
        end
        p = pa;
        f = fault;
        walked = bus_req_seen;
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_walk(input string name);
        if (seen_addrs.size() != exp_addrs.size()) begin
            $display("Mismatch %s bus addr count expected %0d actual %0d", name,
                     exp_addrs.size(), seen_addrs.size());
            errors++;
        end else begin
            foreach (exp_addrs[i]) check(name, 64'(exp_addrs[i]), 64'(seen_addrs[i]));
        end
        check({name, " acked beats"}, 64'(mmu_pkg::LINE_BEATS * exp_addrs.size()),
              64'(acked_beats));
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        $display("test %s: %0d errors", name, errors - e0);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check("reset ready", 1, ready);
        check("reset resp_valid", 0, resp_valid);
        check("reset bus_req", 0, bus_req);
        check("reset bus_busy", 0, bus_busy);
        check("reset bus_req_cyc", 0, bus_req_cyc);
        check("reset bus_resp_ack", 0, bus_resp_ack);
        report("reset", e0);
    endtask

    task automatic test_miss_hit();
        mmu_pkg::vaddr_t v;
        mmu_pkg::ppn_t root, leaf;
        mmu_pkg::paddr_t p;
        logic f, w;
        int lat, e0;
        e0 = errors;
        v = {$random(seed), $random(seed)};
        build_tables(v, 0, 0, root, leaf);
        translate(v, root, p, f, lat, w);
        check("miss pa", {leaf, v[11:0]}, p);
        check("miss fault", 0, f);
        check_walk("miss bus_addr");
        report("miss", e0);
        e0 = errors;
        v[11:0] = v[11:0] ^ 12'h5a8;  // same page, new offset.
        translate(v, root, p, f, lat, w);
        check("hit pa", {leaf, v[11:0]}, p);
        check("hit latency", 1, lat);
        check("hit bus_req", 0, w);
        report("hit", e0);
    endtask

    task automatic fault_case(input string name, input int kind, input int flevel);
        mmu_pkg::vaddr_t v;
        mmu_pkg::ppn_t root, leaf;
        mmu_pkg::paddr_t p;
        logic f, w;
        int lat, e0;
        e0 = errors;
        v = {$random(seed), $random(seed)};
        build_tables(v, kind, flevel, root, leaf);
        for (int n = 0; n < 2; n++) begin
            translate(v, root, p, f, lat, w);
            check(name, 1, f);
            check({name, " walked"}, 1, w);
            check_walk({name, " bus_addr"});
        end
        report(name, e0);
    endtask

    task automatic test_flush();
        mmu_pkg::vaddr_t v;
        mmu_pkg::ppn_t root, leaf;
        mmu_pkg::paddr_t p;
        logic f, w;
        int lat, e0;
        e0 = errors;
        v = {$random(seed), $random(seed)};
        build_tables(v, 0, 0, root, leaf);
        translate(v, root, p, f, lat, w);
        translate(v, root, p, f, lat, w);
        check("flush prior hit", 0, w);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        translate(v, root, p, f, lat, w);
        check("flush walked", 1, w);
        check("flush pa", {leaf, v[11:0]}, p);
        report("flush", e0);
    endtask

    task automatic test_replace();
        mmu_pkg::vaddr_t vs [9];
        mmu_pkg::ppn_t roots [9];
        mmu_pkg::ppn_t leafs [9];
        mmu_pkg::paddr_t p;
        logic f, w;
        int lat, e0;
        e0 = errors;
        for (int i = 0; i < 9; i++) begin
            vs[i] = {$random(seed), $random(seed)};
            build_tables(vs[i], 0, 0, roots[i], leafs[i]);
            translate(vs[i], roots[i], p, f, lat, w);
            check("replace fill pa", {leafs[i], vs[i][11:0]}, p);
        end
        translate(vs[0], roots[0], p, f, lat, w);
        check("replace first walked", 1, w);
        check("replace first pa", {leafs[0], vs[0][11:0]}, p);
        translate(vs[8], roots[8], p, f, lat, w);
        check("replace ninth walked", 0, w);
        check("replace ninth pa", {leafs[8], vs[8][11:0]}, p);
        report("replace", e0);
    endtask

    initial begin
        req_valid = 1'b0;
        flush = 1'b0;
        va = '0;
        satp_ppn = '0;
        bus_grant = 1'b0;
        bus_resp_cyc = 1'b0;
        bus_resp = '0;
        bus_req_seen = 1'b0;
        acked_beats = 0;
        @(negedge reset);
        @(negedge clk);
        test_reset();
        test_miss_hit();
        fault_case("invalid level 2", 1, 2);
        fault_case("leaf level 1", 2, 1);
        fault_case("non-leaf level 3", 3, 3);
        test_flush();
        test_replace();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired, run did not finish");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mmu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mmu_asserts (
    input wire logic clk,
    input wire logic reset,
    input wire logic bus_req,
    input wire logic bus_grant,
    input wire logic bus_busy,
    input wire logic bus_req_cyc,
    input wire logic ready,
    input wire logic resp_valid
);

    // one granted address phase, then the tenure stays busy.
    req_cyc_granted: assert property (@(posedge clk) disable iff (reset)
        bus_req_cyc |=> ($past(bus_grant) && $past(bus_req) && bus_busy && !bus_req_cyc))
        else $error("bus_req_cyc not a single granted pulse of a busy bus");

    resp_single: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held for two cycles");

    busy_not_ready: assert property (@(posedge clk) disable iff (reset)
        bus_busy |-> !ready)
        else $error("ready high while bus busy");

endmodule

bind mmu_top tb_mmu_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .bus_req     (bus_req),
    .bus_grant   (bus_grant),
    .bus_busy    (bus_busy),
    .bus_req_cyc (bus_req_cyc),
    .ready       (ready),
    .resp_valid  (resp_valid)
);

`default_nettype wire

// ==== tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb (
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,
    input  mmu_pkg::vpn_t lookup_vpn,
    output logic          hit,
    output mmu_pkg::ppn_t hit_ppn,
    input  logic          refill,
    input  mmu_pkg::vpn_t refill_vpn,
    input  mmu_pkg::ppn_t refill_ppn
);

    localparam int PTR_W = $clog2(mmu_pkg::TLB_ENTRIES);

    logic [mmu_pkg::TLB_ENTRIES-1:0] valid;
    logic [mmu_pkg::TLB_ENTRIES-1:0] match;
    logic [PTR_W-1:0]                rr_ptr;

    mmu_pkg::vpn_t tag_mem [mmu_pkg::TLB_ENTRIES];
    mmu_pkg::ppn_t ppn_mem [mmu_pkg::TLB_ENTRIES];

    always_comb begin
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            match[i] = valid[i] && (tag_mem[i] == lookup_vpn);
        end
    end

    assign hit = |match;

    // at most one entry matches, so an or of the gated entries is enough
    always_comb begin
        hit_ppn = '0;
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit_ppn = hit_ppn | ppn_mem[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (flush) begin
            valid <= '0;  // flush wins over a refill.
        end else if (refill) begin
            valid[rr_ptr] <= 1'b1;
            rr_ptr        <= rr_ptr + 1'b1;  // wraps over all entries.
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tag_mem[rr_ptr] <= refill_vpn;
            ppn_mem[rr_ptr] <= refill_ppn;
        end
    end

endmodule

`default_nettype wire

// ==== translate_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module translate_ctrl (
    input  logic            clk,
    input  logic            reset,
    input  logic            req_valid,
    input  mmu_pkg::vaddr_t va,
    output logic            ready,
    output logic            resp_valid,
    output mmu_pkg::paddr_t pa,
    output logic            fault,
    output mmu_pkg::vpn_t   lookup_vpn,
    input  logic            hit,
    input  mmu_pkg::ppn_t   hit_ppn,
    output logic            refill,
    output mmu_pkg::vpn_t   refill_vpn,
    output mmu_pkg::ppn_t   refill_ppn,
    walk_if.ctrl            walk
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WALKING,
        S_RESPOND
    } state_t;

    state_t          state;
    mmu_pkg::vaddr_t va_q;
    mmu_pkg::vpn_t   req_vpn;
    mmu_pkg::ppn_t   walk_ppn_q;
    logic            walk_fault_q;
    mmu_pkg::ppn_t   resp_ppn;

    assign req_vpn = va_q[mmu_pkg::VA_W-1:mmu_pkg::PAGE_OFFSET_W];

    assign ready      = (state == S_IDLE);
    assign lookup_vpn = req_vpn;

    assign walk.start = (state == S_LOOKUP) && !hit;  // miss.
    assign walk.vpn   = req_vpn;

    // a hit answers straight from the lookup cycle
    assign resp_valid = ((state == S_LOOKUP) && hit) || (state == S_RESPOND);
    assign resp_ppn   = (state == S_LOOKUP) ? hit_ppn : walk_ppn_q;
    assign pa         = {resp_ppn, va_q[mmu_pkg::PAGE_OFFSET_W-1:0]};
    assign fault      = (state == S_RESPOND) && walk_fault_q;

    assign refill     = (state == S_RESPOND) && !walk_fault_q;  // faults are not cached.
    assign refill_vpn = req_vpn;
    assign refill_ppn = walk_ppn_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP:  state <= hit ? S_IDLE : S_WALKING;
                S_WALKING: begin
                    if (walk.done) begin
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ready && req_valid) begin
            va_q <= va;
        end
        if ((state == S_WALKING) && walk.done) begin
            walk_ppn_q   <= walk.ppn;
            walk_fault_q <= walk.fault;
        end
    end

endmodule

`default_nettype wire

// ==== walk_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface walk_if;

    logic          start;  // one cycle pulse.
    mmu_pkg::vpn_t vpn;
    logic          done;   // one cycle pulse.
    mmu_pkg::ppn_t ppn;    // valid with done.
    logic          fault;  // valid with done.

    modport ctrl (
        output start,
        output vpn,
        input  done,
        input  ppn,
        input  fault
    );

    modport walker (
        input  start,
        input  vpn,
        output done,
        output ppn,
        output fault
    );

endinterface

`default_nettype wire
